//--- riscv_soc.f
hdl/riscv_pkg.sv
hdl/unified_ram.sv
hdl/mem_arbiter.sv
hdl/register.sv
hdl/id_unit.sv
hdl/ex.sv
hdl/hazard_detection.sv
hdl/riscv.sv
hdl/riscv_soc.sv
verification/riscv_soc_asserts.sv
verification/riscv_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module riscv_soc_tb -f riscv_soc.f \
    && ./obj_dir/Vriscv_soc_tb | tee /dev/stderr | grep -qx "test passed" \
    || exit 1

//--- verification/riscv_soc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_soc_tb import riscv_pkg::*; ();

    localparam int DATA_W  = 256;   // Byte 0x400
    localparam int RES_W   = 320;   // Byte 0x500
    localparam int DONE_W  = 508;   // Byte 0x7F0
    localparam int SCRATCH = 600;
    localparam int POLLS   = 300;
    localparam int GNT_MAX = 100;

    logic              clk;
    logic              rst_n_i;
    logic              halt_i;
    logic              host_req_i;
    logic              host_we_i;
    logic [MEM_AW-1:0] host_addr_i;
    logic [XLEN-1:0]   host_wdata_i;
    logic [XLEN-1:0]   host_rdata_o;
    logic              host_gnt_o;

    logic [31:0] rng;
    logic [31:0] ops [8];   // Operands written into the data area
    logic [31:0] prog [$];
    int          errors;
    int          checks;
    int          test_errors;
    int          test_checks;

    riscv_soc riscv_soc_i (
        .clk          (clk         ),
        .rst_n_i      (rst_n_i     ),
        .halt_i       (halt_i      ),
        .host_req_i   (host_req_i  ),
        .host_we_i    (host_we_i   ),
        .host_addr_i  (host_addr_i ),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o),
        .host_gnt_o   (host_gnt_o  )
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Expected memory words for kind 0 chain, 1 load-use or 2 branch loop
    function automatic logic [31:0] ref_result(input int kind, input int idx);
        logic [31:0] r [9];
        logic [31:0] sum;
        sum = '0;
        if (kind == 2) begin
            for (int i = 0; i < 8; i++) begin
                sum = sum + ops[i];
            end
            return (idx == 0) ? sum : 32'd1;   // Counter after the loop runs once
        end
        if (kind == 1) begin
            return ops[0] + ops[1];
        end
        r[0] = ops[0] + ops[1];
        r[1] = r[0] - ops[1];
        r[2] = r[1] & r[0];
        r[3] = r[2] | ops[0];
        r[4] = r[3] ^ r[1];
        r[5] = ($signed(r[4]) < $signed(r[0])) ? 32'd1 : 32'd0;
        r[6] = r[5] - 32'd5;
        r[7] = 32'hABCDE000;
        r[8] = r[7] + r[6];
        return r[idx];
    endfunction

    // Called at 2 ns after an edge, returns at the same phase
    task automatic host_cycle(input logic we, input int addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        waited       = 0;
        host_req_i   = 1'b1;
        host_we_i    = we;
        host_addr_i  = MEM_AW'(addr);
        host_wdata_i = wdata;
        #1;
        while (!host_gnt_o && waited < GNT_MAX) begin
            @(posedge clk);
            #3;
            waited++;
        end
        if (!host_gnt_o) begin
            $display("Host access to word %0d was never granted", addr);
            errors++;
            test_errors++;
        end
        rdata = host_rdata_o;
        @(posedge clk);
        #2;
        host_req_i = 1'b0;
        host_we_i  = 1'b0;
    endtask

    task automatic host_write(input int addr, input logic [31:0] wdata);
        logic [31:0] unused;
        host_cycle(1'b1, addr, wdata, unused);
    endtask

    task automatic host_read(input int addr, output logic [31:0] rdata);
        host_cycle(1'b0, addr, '0, rdata);
    endtask

    task automatic check_word(input string name, input int addr, input logic [31:0] expected);
        logic [31:0] actual;
        host_read(addr, actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            $display("ERR %s word %0d: expected %08h actual %08h", name, addr, expected,
                     actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic reset_core();
        rst_n_i = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
    endtask

    // Core halted and reset, result area and done word cleared
    task automatic prepare(input int n_ops);
        halt_i = 1'b1;
        reset_core();
        for (int i = 0; i < 9; i++) begin
            host_write(RES_W + i, '0);
        end
        host_write(DONE_W, '0);
        for (int i = 0; i < n_ops; i++) begin
            rng    = lcg(rng);
            ops[i] = rng;
            host_write(DATA_W + i, ops[i]);
        end
        for (int i = 0; i < prog.size(); i++) begin
            host_write(i, prog[i]);
        end
        for (int i = 0; i < 4; i++) begin
            host_write(prog.size() + i, '0);   // No-ops after the last jump
        end
    endtask

    task automatic push_done();
        prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd12, OP_I));
        prog.push_back(enc_s(12'h7F0, 5'd12, 5'd0));
        prog.push_back(enc_jal(5'd0, 21'd0));   // Spin here
    endtask

    // Poll with gaps so the core still gets the memory
    task automatic run_until_done(input string name, input bit random_gap);
        logic [31:0] done;
        int          polls;
        int          gap;
        done   = '0;
        polls  = 0;
        halt_i = 1'b0;
        while (done !== 32'd1 && polls < POLLS) begin
            host_read(DONE_W, done);
            rng = lcg(rng);
            gap = random_gap ? 1 + int'(rng[17:16]) % 3 : 6;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            polls++;
        end
        halt_i = 1'b1;
        if (done !== 32'd1) begin
            $display("%s: program never set its done word", name);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic build_chain();
        prog.delete();
        prog.push_back(enc_i(12'h400, 5'd0, 3'b010, 5'd1, OP_LOAD));
        prog.push_back(enc_i(12'h404, 5'd0, 3'b010, 5'd2, OP_LOAD));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));   // add
        prog.push_back(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));   // sub
        prog.push_back(enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));   // and
        prog.push_back(enc_r(7'h00, 5'd1, 5'd5, 3'b110, 5'd6));   // or
        prog.push_back(enc_r(7'h00, 5'd4, 5'd6, 3'b100, 5'd7));   // xor
        prog.push_back(enc_r(7'h00, 5'd3, 5'd7, 3'b010, 5'd8));   // slt
        prog.push_back(enc_i(12'hFFB, 5'd8, 3'b000, 5'd9, OP_I));
        prog.push_back({20'hABCDE, 5'd10, OP_LUI});
        prog.push_back(enc_r(7'h00, 5'd9, 5'd10, 3'b000, 5'd11));
        for (int k = 0; k < 9; k++) begin
            prog.push_back(enc_s(12'(12'h500 + 4 * k), 5'(3 + k), 5'd0));
        end
        push_done();
    endtask

    task automatic check_chain(input string name);
        for (int k = 0; k < 9; k++) begin
            check_word(name, RES_W + k, ref_result(0, k));
        end
    endtask

    initial begin
        logic [31:0] words [16];
        logic [31:0] got;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        halt_i       = 1'b1;
        host_req_i   = 1'b0;
        host_we_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        rng          = 32'h9b69;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        test_checks  = 0;
        @(posedge clk);
        #2;
        reset_core();

        checks++;
        test_checks++;
        if (host_gnt_o !== 1'b0) begin
            $display("ERR host_round_trip host_gnt_o: expected 0 actual %b", host_gnt_o);
            errors++;
            test_errors++;
        end
        for (int i = 0; i < 16; i++) begin
            rng      = lcg(rng);
            words[i] = rng;
            host_write(SCRATCH + i, words[i]);
        end
        for (int i = 0; i < 16; i++) begin
            check_word("host_round_trip", SCRATCH + i, words[i]);
        end
        end_test("host_round_trip");

        build_chain();
        prepare(2);
        run_until_done("arith_chain", 1'b0);
        check_chain("arith_chain");
        end_test("arith_chain");

        prog.delete();
        prog.push_back(enc_i(12'h400, 5'd0, 3'b010, 5'd1, OP_LOAD));
        prog.push_back(enc_i(12'h404, 5'd0, 3'b010, 5'd2, OP_LOAD));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));   // Uses x2 at once
        prog.push_back(enc_s(12'h500, 5'd3, 5'd0));
        push_done();
        prepare(2);
        run_until_done("load_use", 1'b0);
        check_word("load_use", RES_W, ref_result(1, 0));
        end_test("load_use");

        prog.delete();
        prog.push_back(enc_i(12'h400, 5'd0, 3'b000, 5'd1, OP_I));   // Pointer
        prog.push_back(enc_i(12'd8, 5'd0, 3'b000, 5'd2, OP_I));     // Count
        prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd3, OP_I));     // Sum
        prog.push_back(enc_i(12'd0, 5'd1, 3'b010, 5'd4, OP_LOAD));
        prog.push_back(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd3));
        prog.push_back(enc_i(12'd4, 5'd1, 3'b000, 5'd1, OP_I));
        prog.push_back(enc_i(12'hFFF, 5'd2, 3'b000, 5'd2, OP_I));
        prog.push_back(enc_b(13'h1FF0, 5'd0, 5'd2, 3'b001));       // bne back to the load
        prog.push_back(enc_i(12'd1, 5'd8, 3'b000, 5'd8, OP_I));     // Runs once only
        prog.push_back(enc_s(12'h500, 5'd3, 5'd0));
        prog.push_back(enc_s(12'h508, 5'd8, 5'd0));
        prog.push_back(enc_jal(5'd0, 21'd12));
        prog.push_back(enc_s(12'h504, 5'd3, 5'd0));                // Sentinel store the JAL skips
        prog.push_back(enc_s(12'h504, 5'd3, 5'd0));
        push_done();
        prepare(8);
        rng = lcg(rng);
        got = rng;
        host_write(RES_W + 1, got);
        run_until_done("branch_loop", 1'b0);
        check_word("branch_loop", RES_W, ref_result(2, 0));
        check_word("branch_loop", RES_W + 2, ref_result(2, 1));
        check_word("branch_loop", RES_W + 1, got);
        end_test("branch_loop");

        build_chain();
        prepare(2);
        run_until_done("contention", 1'b1);
        check_chain("contention");
        end_test("contention");

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/riscv_soc_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_soc_asserts import riscv_pkg::*; (
    input logic     clk,
    input logic     rst_n_i,
    input mem_req_t host_req,
    input logic     host_gnt,
    input mem_req_t data_req,
    input logic     data_busy,
    input mem_req_t fetch_req,
    input logic     fetch_busy,
    input logic     id_ex_wen,
    input logic     mem_wb_wen
);

    logic data_gnt;
    logic fetch_gnt;

    assign data_gnt  = data_req.req && !data_busy;
    assign fetch_gnt = fetch_req.req && !fetch_busy;

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({host_gnt, data_gnt, fetch_gnt}))
        else $error("more than one requester granted");

    a_host_first: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_req.req |-> host_gnt && !data_gnt && !fetch_gnt)
        else $error("host request lost arbitration");

    // Pipeline control quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !data_req.req && !id_ex_wen && !mem_wb_wen)
        else $error("memory or register enable active in reset");

endmodule

bind riscv_soc riscv_soc_asserts riscv_soc_asserts_i (
    .clk        (clk                       ),
    .rst_n_i    (rst_n_i                   ),
    .host_req   (host_req                  ),
    .host_gnt   (host_gnt_o                ),
    .data_req   (data_req                  ),
    .data_busy  (data_busy                 ),
    .fetch_req  (fetch_req                 ),
    .fetch_busy (fetch_busy                ),
    .id_ex_wen  (riscv_i.id_ex_q.ctrl.wen  ),
    .mem_wb_wen (riscv_i.mem_wb_q.wen      )
);

`default_nettype wire

//--- hdl/riscv_soc.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_soc import riscv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              halt_i,
    input  logic              host_req_i,
    input  logic              host_we_i,
    input  logic [MEM_AW-1:0] host_addr_i,
    input  logic [XLEN-1:0]   host_wdata_i,
    output logic [XLEN-1:0]   host_rdata_o,
    output logic              host_gnt_o
);

    mem_req_t        host_req;
    mem_req_t        fetch_req;
    mem_req_t        data_req;
    mem_req_t        mem_req;
    logic [XLEN-1:0] mem_rdata;   // Shared by all requesters
    logic            fetch_busy;
    logic            data_busy;

    assign host_req     = '{req: host_req_i, we: host_we_i, addr: host_addr_i,
                            wdata: host_wdata_i};
    assign host_rdata_o = mem_rdata;

    riscv riscv_i (
        .clk          (clk       ),
        .rst_n_i      (rst_n_i   ),
        .halt_i       (halt_i    ),
        .fetch_busy_i (fetch_busy),
        .data_busy_i  (data_busy ),
        .mem_rdata_i  (mem_rdata ),
        .fetch_req_o  (fetch_req ),
        .data_req_o   (data_req  )
    );

    mem_arbiter mem_arbiter_i (
        .host_i       (host_req  ),
        .data_i       (data_req  ),
        .fetch_i      (fetch_req ),
        .mem_o        (mem_req   ),
        .host_gnt_o   (host_gnt_o),
        .data_busy_o  (data_busy ),
        .fetch_busy_o (fetch_busy)
    );

    unified_ram unified_ram_i (
        .clk     (clk      ),
        .mem_i   (mem_req  ),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/riscv.sv
`timescale 1ns/100ps
`default_nettype none

module riscv import riscv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            halt_i,
    input  logic            fetch_busy_i,
    input  logic            data_busy_i,
    input  logic [XLEN-1:0] mem_rdata_i,
    output mem_req_t        fetch_req_o,
    output mem_req_t        data_req_o
);

    logic [XLEN-1:0]   pc_q;
    if_id_t            if_id_q;
    id_ex_t            id_ex_q;
    ex_mem_t           ex_mem_q;
    mem_wb_t           mem_wb_q;

    logic [REG_AW-1:0] id_rs1;
    logic [REG_AW-1:0] id_rs2;
    logic [REG_AW-1:0] id_rd;
    logic [XLEN-1:0]   id_rs1_data;
    logic [XLEN-1:0]   id_rs2_data;
    logic [XLEN-1:0]   id_imm;
    ctrl_t             id_ctrl;

    logic [XLEN-1:0]   ex_result;
    logic [XLEN-1:0]   ex_store_data;
    logic [XLEN-1:0]   jump_addr;
    logic              jump;
    logic [XLEN-1:0]   wb_data;

    logic              stall;        // Hold PC and IF/ID, bubble into EX
    logic              freeze_all;   // Data access waiting, nothing moves
    logic              flush;
    fwd_sel_e          fwd_rs1;
    fwd_sel_e          fwd_rs2;

    // Fetch stays quiet while halted so the host sees an idle memory
    assign fetch_req_o = '{req: !halt_i, we: 1'b0, addr: pc_q[MEM_AW+1:2], wdata: '0};

    assign data_req_o  = '{req: ex_mem_q.rmem || ex_mem_q.wmem, we: ex_mem_q.wmem,
                           addr: ex_mem_q.result[MEM_AW+1:2], wdata: ex_mem_q.store_data};

    assign wb_data = mem_wb_q.rmem ? mem_wb_q.load_data : mem_wb_q.result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_PC;
            if_id_q <= '0;
        end else if (!freeze_all) begin
            if (flush) begin
                pc_q    <= jump_addr;   // Redirect wins over any stall
                if_id_q <= '0;
            end else if (!stall) begin
                pc_q    <= pc_q + 32'd4;
                if_id_q <= '{pc: pc_q, inst: mem_rdata_i};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (!freeze_all) begin
            if (flush || stall) begin
                id_ex_q <= '0;
            end else begin
                id_ex_q <= '{pc: if_id_q.pc, rs1_addr: id_rs1, rs2_addr: id_rs2,
                             rs1_data: id_rs1_data, rs2_data: id_rs2_data,
                             rd: id_rd, imm: id_imm, ctrl: id_ctrl};
            end
        end
    end

    // MEM/WB holds too, so the WB forward stays valid for a frozen EX
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else if (!freeze_all) begin
            ex_mem_q <= '{result: ex_result, store_data: ex_store_data, rd: id_ex_q.rd,
                          rmem: id_ex_q.ctrl.rmem, wmem: id_ex_q.ctrl.wmem,
                          wen: id_ex_q.ctrl.wen};
            mem_wb_q <= '{result: ex_mem_q.result, load_data: mem_rdata_i,
                          rd: ex_mem_q.rd, rmem: ex_mem_q.rmem, wen: ex_mem_q.wen};
        end
    end

    id_unit id_unit_i (
        .inst_i     (if_id_q.inst),
        .rs1_addr_o (id_rs1      ),
        .rs2_addr_o (id_rs2      ),
        .rd_addr_o  (id_rd       ),
        .imm_o      (id_imm      ),
        .ctrl_o     (id_ctrl     )
    );

    register register_i (
        .clk         (clk         ),
        .rst_n_i     (rst_n_i     ),
        .rs1_raddr_i (id_rs1      ),
        .rs2_raddr_i (id_rs2      ),
        .rd_waddr_i  (mem_wb_q.rd ),
        .rd_wdata_i  (wb_data     ),
        .wen_i       (mem_wb_q.wen),
        .rs1_rdata_o (id_rs1_data ),
        .rs2_rdata_o (id_rs2_data )
    );

    ex ex_i (
        .id_ex_i      (id_ex_q        ),
        .mem_fwd_i    (ex_mem_q.result),
        .wb_fwd_i     (wb_data        ),
        .fwd_rs1_i    (fwd_rs1        ),
        .fwd_rs2_i    (fwd_rs2        ),
        .result_o     (ex_result      ),
        .store_data_o (ex_store_data  ),
        .jump_o       (jump           ),
        .jump_addr_o  (jump_addr      )
    );

    hazard_detection hazard_detection_i (
        .id_rs1_i     (id_rs1      ),
        .id_rs2_i     (id_rs2      ),
        .id_ex_i      (id_ex_q     ),
        .ex_mem_i     (ex_mem_q    ),
        .mem_wb_i     (mem_wb_q    ),
        .jump_i       (jump        ),
        .halt_i       (halt_i      ),
        .fetch_busy_i (fetch_busy_i),
        .data_busy_i  (data_busy_i ),
        .stall_o      (stall       ),
        .freeze_all_o (freeze_all  ),
        .flush_o      (flush       ),
        .fwd_rs1_o    (fwd_rs1     ),
        .fwd_rs2_o    (fwd_rs2     )
    );

endmodule

`default_nettype wire

//--- hdl/hazard_detection.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detection import riscv_pkg::*; (
    input  logic [REG_AW-1:0] id_rs1_i,
    input  logic [REG_AW-1:0] id_rs2_i,
    input  id_ex_t            id_ex_i,
    input  ex_mem_t           ex_mem_i,
    input  mem_wb_t           mem_wb_i,
    input  logic              jump_i,
    input  logic              halt_i,
    input  logic              fetch_busy_i,
    input  logic              data_busy_i,
    output logic              stall_o,
    output logic              freeze_all_o,
    output logic              flush_o,
    output fwd_sel_e          fwd_rs1_o,
    output fwd_sel_e          fwd_rs2_o
);

    logic load_use;

    // Load in EX, consumer in ID; one bubble puts the load in WB in time
    assign load_use = id_ex_i.ctrl.rmem && (id_ex_i.rd != '0) &&
                      (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

    assign stall_o      = load_use || fetch_busy_i || halt_i;
    assign freeze_all_o = data_busy_i;
    assign flush_o      = jump_i && !data_busy_i;   // Branch must wait in EX too

    // Youngest producer wins
    function automatic fwd_sel_e fwd_src(input logic [REG_AW-1:0] rs);
        if (ex_mem_i.wen && ex_mem_i.rd != '0 && ex_mem_i.rd == rs) begin
            return FWD_MEM;
        end else if (mem_wb_i.wen && mem_wb_i.rd != '0 && mem_wb_i.rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_rs1_o = fwd_src(id_ex_i.rs1_addr);
        fwd_rs2_o = fwd_src(id_ex_i.rs2_addr);
    end

endmodule

`default_nettype wire

//--- hdl/ex.sv
`timescale 1ns/100ps
`default_nettype none

module ex import riscv_pkg::*; (
    input  id_ex_t          id_ex_i,
    input  logic [XLEN-1:0] mem_fwd_i,
    input  logic [XLEN-1:0] wb_fwd_i,
    input  fwd_sel_e        fwd_rs1_i,
    input  fwd_sel_e        fwd_rs2_i,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] store_data_o,
    output logic            jump_o,
    output logic [XLEN-1:0] jump_addr_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;   // Forwarded rs2, before the imm mux
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic            equal;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [XLEN-1:0] rf,
                                                input logic [XLEN-1:0] mem,
                                                input logic [XLEN-1:0] wb);
        case (sel)
            FWD_MEM: return mem;
            FWD_WB:  return wb;
            default: return rf;
        endcase
    endfunction

    assign op_a    = fwd_mux(fwd_rs1_i, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
    assign rs2_val = fwd_mux(fwd_rs2_i, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);
    assign op_b    = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    assign result_o     = id_ex_i.ctrl.jal ? id_ex_i.pc + 32'd4 : alu_out;   // Link address
    assign store_data_o = rs2_val;

    assign equal       = (op_a == rs2_val);
    assign jump_o      = id_ex_i.ctrl.jal || (id_ex_i.ctrl.br_eq && equal) ||
                         (id_ex_i.ctrl.br_ne && !equal);
    assign jump_addr_o = id_ex_i.pc + id_ex_i.imm;

endmodule

`default_nettype wire

//--- hdl/id_unit.sv
`timescale 1ns/100ps
`default_nettype none

module id_unit import riscv_pkg::*; (
    input  inst_u             inst_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    output logic [REG_AW-1:0] rd_addr_o,
    output logic [XLEN-1:0]   imm_o,
    output ctrl_t             ctrl_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;

    // Register fields sit at the same bits in every format
    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;
    assign rd_addr_o  = inst_i.r.rd;

    assign imm_i = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_b = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                    inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
    assign imm_j = {{11{inst_i.u.imm[19]}}, inst_i.u.imm[19], inst_i.u.imm[7:0],
                    inst_i.u.imm[8], inst_i.u.imm[18:9], 1'b0};
    assign imm_u = {inst_i.u.imm, 12'b0};

    always_comb begin
        ctrl_o = '0;   // Anything not matched below is a no-op
        imm_o  = '0;
        case (inst_i.r.opcode)
            OP_R: begin
                ctrl_o.wen = 1'b1;
                case (inst_i.r.funct3)
                    3'b000:  ctrl_o.alu_op = inst_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl_o.alu_op = ALU_SLT;
                    3'b100:  ctrl_o.alu_op = ALU_XOR;
                    3'b110:  ctrl_o.alu_op = ALU_OR;
                    3'b111:  ctrl_o.alu_op = ALU_AND;
                    default: ctrl_o.wen    = 1'b0;   // Shifts, SLTU
                endcase
            end
            OP_I: begin
                imm_o          = imm_i;
                ctrl_o.wen     = (inst_i.i.funct3 == 3'b000);   // ADDI only
                ctrl_o.use_imm = 1'b1;
            end
            OP_LOAD: begin
                imm_o          = imm_i;
                ctrl_o.rmem    = (inst_i.i.funct3 == 3'b010);   // LW
                ctrl_o.wen     = ctrl_o.rmem;
                ctrl_o.use_imm = 1'b1;
            end
            OP_STORE: begin
                imm_o          = imm_s;
                ctrl_o.wmem    = (inst_i.s.funct3 == 3'b010);   // SW
                ctrl_o.use_imm = 1'b1;
            end
            OP_BRANCH: begin
                imm_o        = imm_b;
                ctrl_o.br_eq = (inst_i.b.funct3 == 3'b000);
                ctrl_o.br_ne = (inst_i.b.funct3 == 3'b001);
            end
            OP_JAL: begin
                imm_o      = imm_j;
                ctrl_o.jal = 1'b1;
                ctrl_o.wen = 1'b1;
            end
            OP_LUI: begin
                imm_o          = imm_u;
                ctrl_o.wen     = 1'b1;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.alu_op  = ALU_PASS_B;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/register.sv
`timescale 1ns/100ps
`default_nettype none

module register import riscv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [REG_AW-1:0] rs1_raddr_i,
    input  logic [REG_AW-1:0] rs2_raddr_i,
    input  logic [REG_AW-1:0] rd_waddr_i,
    input  logic [XLEN-1:0]   rd_wdata_i,
    input  logic              wen_i,
    output logic [XLEN-1:0]   rs1_rdata_o,
    output logic [XLEN-1:0]   rs2_rdata_o
);

    logic [XLEN-1:0] regs_q [2**REG_AW];

    // Write-first, so WB and ID may touch the same register in one cycle
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wen_i && rd_waddr_i == addr) begin
            return rd_wdata_i;
        end
        return regs_q[addr];
    endfunction

    always_comb begin
        rs1_rdata_o = read_port(rs1_raddr_i);
        rs2_rdata_o = read_port(rs2_raddr_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && rd_waddr_i != '0) begin   // x0 never written
            regs_q[rd_waddr_i] <= rd_wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import riscv_pkg::*; (
    input  mem_req_t host_i,
    input  mem_req_t data_i,
    input  mem_req_t fetch_i,
    output mem_req_t mem_o,
    output logic     host_gnt_o,
    output logic     data_busy_o,
    output logic     fetch_busy_o
);

    logic data_gnt;
    logic fetch_gnt;

    // Host, then data, then fetch
    assign host_gnt_o = host_i.req;
    assign data_gnt   = data_i.req && !host_i.req;
    assign fetch_gnt  = fetch_i.req && !host_i.req && !data_i.req;

    assign data_busy_o  = data_i.req && !data_gnt;    // Asked and lost
    assign fetch_busy_o = fetch_i.req && !fetch_gnt;

    always_comb begin
        if (host_gnt_o) begin
            mem_o = host_i;
        end else if (data_gnt) begin
            mem_o = data_i;
        end else if (fetch_gnt) begin
            mem_o = fetch_i;
        end else begin
            mem_o = '0;   // Idle, no write
        end
    end

endmodule

`default_nettype wire

//--- hdl/unified_ram.sv
`timescale 1ns/100ps
`default_nettype none

module unified_ram import riscv_pkg::*; (
    input  logic            clk,
    input  mem_req_t        mem_i,
    output logic [XLEN-1:0] rdata_o
);

    logic [XLEN-1:0] mem_q [MEM_WORDS];

    // Read data in the same cycle as the granted request
    assign rdata_o = mem_q[mem_i.addr];

    always_ff @(posedge clk) begin
        if (mem_i.req && mem_i.we) begin
            mem_q[mem_i.addr] <= mem_i.wdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    localparam int unsigned     XLEN      = 32;
    localparam int unsigned     REG_AW    = 5;
    localparam int unsigned     MEM_WORDS = 1024;
    localparam int unsigned     MEM_AW    = 10;   // Word address
    localparam logic [XLEN-1:0] RESET_PC  = '0;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B   // LUI takes the immediate as is
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // Also carries the scrambled J immediate of JAL
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } inst_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // Operand b from imm
        logic    rmem;
        logic    wmem;
        logic    wen;       // Register write
        logic    br_eq;
        logic    br_ne;
        logic    jal;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs1_addr;
        logic [REG_AW-1:0] rs2_addr;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;
        ctrl_t             ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
        logic              rmem;
        logic              wmem;
        logic              wen;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   load_data;
        logic [REG_AW-1:0] rd;
        logic              rmem;
        logic              wen;
    } mem_wb_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [MEM_AW-1:0] addr;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

endpackage

`default_nettype wire
